//--- tlb_defs.svh
// TLB configuration macros: page widths, geometry, fill bubble and lookup latency
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// Virtual and physical page index widths, one page size only
`define TLB_VA_PAGE_BITS 20
`define TLB_PA_PAGE_BITS 20

// Set-associative geometry. The set index is taken from the low virtual page bits
`define TLB_NUM_SETS 16
`define TLB_NUM_WAYS 4

// Idle cycles after an insert before the next fill is accepted
`define TLB_FILL_BUBBLE_CYCLES 8

// Cycles from a sampled lookup_en to its response
`define TLB_LOOKUP_LATENCY 6

`endif

//--- hdl/tlb_pkg.sv
// TLB shared types: page, index, tag and way vectors plus the fill FSM states
`default_nettype none

`include "tlb_defs.svh"

package tlb_pkg;

    // Split of the virtual page into tag and set index
    localparam int TLB_IDX_BITS = $clog2(`TLB_NUM_SETS);
    localparam int TLB_TAG_BITS = `TLB_VA_PAGE_BITS - TLB_IDX_BITS;
    localparam int TLB_WAY_IDX_BITS = $clog2(`TLB_NUM_WAYS);

    typedef logic [`TLB_VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [`TLB_PA_PAGE_BITS-1:0] t_pa_page;
    typedef logic [TLB_IDX_BITS-1:0] t_tlb_idx;
    typedef logic [TLB_TAG_BITS-1:0] t_tlb_tag;
    typedef logic [`TLB_NUM_WAYS-1:0] t_way_vec;
    typedef logic [TLB_WAY_IDX_BITS-1:0] t_way_idx;

    // Fill FSM: accept, pick the victim, write it, then wait out the bubble
    typedef enum logic [1:0]
    {
        fill_idle,
        fill_pick,
        fill_insert,
        fill_bubble
    } t_fill_state;

endpackage

`default_nettype wire

//--- hdl/tlb_way_store.sv
// TLB entry storage with per-way arrays, a two-cycle read port and the flush sweep
`default_nettype none

`include "tlb_defs.svh"

module tlb_way_store
    import tlb_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  t_tlb_idx rd_idx,
    output t_tlb_tag rd_tags [`TLB_NUM_WAYS],
    output t_pa_page rd_pas [`TLB_NUM_WAYS],
    output t_way_vec rd_valid,
    input  t_way_vec wr_ways,
    input  t_tlb_idx wr_idx,
    input  t_tlb_tag wr_tag,
    input  t_pa_page wr_pa,
    input  logic     wr_valid,
    input  t_tlb_idx peek_idx,
    output t_way_vec peek_valid,
    output logic     lookup_rdy
);

    localparam int WAYS = `TLB_NUM_WAYS;
    localparam int SETS = `TLB_NUM_SETS;

    // ========================================================================
    // Entry arrays
    // ========================================================================

    // Tags and physical pages live in one array per way, so a single way
    // is written without touching its neighbours in the set
    t_tlb_tag tag_mem [WAYS][SETS];
    t_pa_page pa_mem [WAYS][SETS];

    // Valid bits are kept per set so the fill controller can peek at a whole set
    t_way_vec valid_mem [SETS];

    // Flush sweep walks the sets, clearing one per cycle
    logic     sweep_active;
    t_tlb_idx sweep_idx;

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            if (wr_ways[w])
            begin
                tag_mem[w][wr_idx] <= wr_tag;
                pa_mem[w][wr_idx] <= wr_pa;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            if (wr_ways[w])
            begin
                valid_mem[wr_idx][w] <= wr_valid;
            end
        end

        // The sweep clear comes last, so it wins over a write to the same set
        if (sweep_active)
        begin
            valid_mem[sweep_idx] <= '0;
        end
    end

    // ========================================================================
    // Sweep control
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            sweep_active <= 1'b1;
            sweep_idx <= '0;
        end
        else if (sweep_active)
        begin
            sweep_idx <= sweep_idx + 1'b1;
            // Last set cleared this cycle
            if (sweep_idx == t_tlb_idx'(SETS - 1))
            begin
                sweep_active <= 1'b0;
            end
        end
    end

    // Lookups are refused while any set may still hold stale valid bits
    assign lookup_rdy = !sweep_active;

    // Victim selection needs the current set's valid bits in the same cycle
    assign peek_valid = valid_mem[peek_idx];

    // ========================================================================
    // Two-cycle registered read
    // ========================================================================

    t_tlb_tag rd_tag_q [WAYS];
    t_pa_page rd_pa_q [WAYS];
    t_way_vec rd_valid_q;

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            rd_tag_q[w] <= tag_mem[w][rd_idx];
            rd_pa_q[w] <= pa_mem[w][rd_idx];
            rd_tags[w] <= rd_tag_q[w];
            rd_pas[w] <= rd_pa_q[w];
        end
        rd_valid_q <= valid_mem[rd_idx];
        rd_valid <= rd_valid_q;
    end

    // The host must wait for lookup_rdy before issuing another flush
    a_no_flush_mid_sweep: assert property (
        @(posedge clk) disable iff (reset) flush |-> !sweep_active
    );

endmodule

`default_nettype wire

//--- hdl/tlb_lookup_pipe.sv
// TLB lookup pipeline: tag compare over all ways and hit or miss response
`default_nettype none

`include "tlb_defs.svh"

module tlb_lookup_pipe
    import tlb_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     lookup_en,
    input  t_va_page lookup_va,
    input  logic     lookup_rdy,
    output t_tlb_idx rd_idx,
    input  t_tlb_tag rd_tags [`TLB_NUM_WAYS],
    input  t_pa_page rd_pas [`TLB_NUM_WAYS],
    input  t_way_vec rd_valid,
    output logic     lookup_rsp_valid,
    output t_pa_page lookup_rsp_pa,
    output logic     lookup_miss,
    output t_va_page lookup_miss_va
);

    localparam int WAYS = `TLB_NUM_WAYS;
    localparam int LAT = `TLB_LOOKUP_LATENCY;

    // Tag is whatever remains above the set index
    function automatic t_tlb_tag target_tag(t_va_page va);
        return va[$bits(t_va_page)-1 -: $bits(t_tlb_tag)];
    endfunction

    // ========================================================================
    // Primary state carried through the stages
    // ========================================================================

    // Stage s holds a lookup during the cycle after its (s-1)th edge
    logic     stg_did [1:4];
    t_va_page stg_va [1:LAT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 1; s <= 4; s++)
            begin
                stg_did[s] <= 1'b0;
            end
        end
        else
        begin
            stg_did[1] <= lookup_en && lookup_rdy;
            for (int s = 1; s < 4; s++)
            begin
                stg_did[s + 1] <= stg_did[s];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stg_va[1] <= lookup_va;
        for (int s = 1; s < LAT; s++)
        begin
            stg_va[s + 1] <= stg_va[s];
        end
    end

    // Stage 0 addresses the store directly; data returns in stage 2
    assign rd_idx = t_tlb_idx'(lookup_va);

    // ========================================================================
    // Split tag compare
    // ========================================================================

    // Stage 2 registers only the XOR, the wide reduction waits a cycle
    t_tlb_tag stg3_xor [WAYS];
    t_way_vec stg3_valid;
    t_pa_page stg3_pas [WAYS];

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            stg3_xor[w] <= rd_tags[w] ^ target_tag(stg_va[2]);
            stg3_pas[w] <= rd_pas[w];
        end
        stg3_valid <= rd_valid;
    end

    // Stage 3 NORs each way's XOR bits down to one match flag
    t_way_vec stg4_match;
    t_pa_page stg4_pas [WAYS];

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            stg4_match[w] <= stg3_valid[w] && !(|stg3_xor[w]);
            stg4_pas[w] <= stg3_pas[w];
        end
    end

    // ========================================================================
    // Hit way selection and response
    // ========================================================================

    logic     stg4_any;
    t_way_idx stg4_way;

    // Lowest matching way wins; a set should never hold duplicates anyway
    always_comb
    begin
        stg4_any = |stg4_match;
        stg4_way = '0;
        for (int w = WAYS - 1; w >= 0; w--)
        begin
            if (stg4_match[w])
            begin
                stg4_way = t_way_idx'(w);
            end
        end
    end

    logic     stg_hit [5:LAT];
    logic     stg_miss [5:LAT];
    t_pa_page stg_pa [5:LAT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 5; s <= LAT; s++)
            begin
                stg_hit[s] <= 1'b0;
                stg_miss[s] <= 1'b0;
            end
        end
        else
        begin
            stg_hit[5] <= stg_did[4] && stg4_any;
            stg_miss[5] <= stg_did[4] && !stg4_any;
            for (int s = 5; s < LAT; s++)
            begin
                stg_hit[s + 1] <= stg_hit[s];
                stg_miss[s + 1] <= stg_miss[s];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stg_pa[5] <= stg4_pas[stg4_way];
        for (int s = 5; s < LAT; s++)
        begin
            stg_pa[s + 1] <= stg_pa[s];
        end
    end

    // Response registers, fed from the last stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_rsp_valid <= 1'b0;
            lookup_miss <= 1'b0;
        end
        else
        begin
            lookup_rsp_valid <= stg_hit[LAT];
            lookup_miss <= stg_miss[LAT];
        end
        lookup_rsp_pa <= stg_pa[LAT];
        // Page is echoed on every response, the walker only needs it on a miss
        lookup_miss_va <= stg_va[LAT];
    end

    // Requests during a flush sweep would read half-cleared sets
    a_lookup_when_rdy: assert property (
        @(posedge clk) disable iff (reset) lookup_en |-> lookup_rdy
    );

endmodule

`default_nettype wire

//--- hdl/tlb_fill_ctrl.sv
// TLB fill controller that picks the victim, writes the insert and applies host invalidations
`default_nettype none

`include "tlb_defs.svh"

module tlb_fill_ctrl
    import tlb_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     fill_en,
    input  t_va_page fill_va,
    input  t_pa_page fill_pa,
    output logic     fill_rdy,
    input  logic     inval_en,
    input  t_va_page inval_va,
    output t_tlb_idx peek_idx,
    input  t_way_vec peek_valid,
    output t_way_vec wr_ways,
    output t_tlb_idx wr_idx,
    output t_tlb_tag wr_tag,
    output t_pa_page wr_pa,
    output logic     wr_valid
);

    localparam int WAYS = `TLB_NUM_WAYS;
    localparam int BUBBLE = `TLB_FILL_BUBBLE_CYCLES;

    t_fill_state fill_state;
    logic [$clog2(BUBBLE)-1:0] bubble_cnt;

    // Captured fill request
    t_tlb_tag req_tag;
    t_tlb_idx req_idx;
    t_pa_page req_pa;

    // Global replacement pointer shared by all sets
    t_way_idx repl_ptr;
    t_way_idx victim;
    t_way_idx victim_way;
    logic     set_full;

    // ========================================================================
    // Victim selection
    // ========================================================================

    assign peek_idx = req_idx;

    // The lowest invalid way is taken first and the rotating pointer only when the set is full
    always_comb
    begin
        set_full = &peek_valid;
        victim = repl_ptr;
        for (int w = WAYS - 1; w >= 0; w--)
        begin
            if (!peek_valid[w])
            begin
                victim = t_way_idx'(w);
            end
        end
    end

    // ========================================================================
    // Fill FSM
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fill_state <= fill_idle;
            fill_rdy <= 1'b0;
            bubble_cnt <= '0;
            repl_ptr <= '0;
        end
        else
        begin
            case (fill_state)
                fill_idle:
                begin
                    // Only one fill is in flight, so ready drops right after acceptance
                    if (fill_en && fill_rdy)
                    begin
                        fill_state <= fill_pick;
                        fill_rdy <= 1'b0;
                    end
                    else
                    begin
                        fill_rdy <= 1'b1;
                    end
                end
                fill_pick:
                begin
                    fill_state <= fill_insert;
                    if (set_full)
                    begin
                        repl_ptr <= repl_ptr + 1'b1;
                    end
                end
                fill_insert:
                begin
                    fill_state <= fill_bubble;
                    bubble_cnt <= '0;
                end
                fill_bubble:
                begin
                    // Gives the new entry time to reach lookups before the
                    // walker can retry the same page
                    bubble_cnt <= bubble_cnt + 1'b1;
                    if (bubble_cnt == ($bits(bubble_cnt))'(BUBBLE - 1))
                    begin
                        fill_state <= fill_idle;
                        fill_rdy <= 1'b1;
                    end
                end
                default:
                begin
                    fill_state <= fill_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_state == fill_idle && fill_en && fill_rdy)
        begin
            {req_tag, req_idx} <= fill_va;
            req_pa <= fill_pa;
        end
        if (fill_state == fill_pick)
        begin
            victim_way <= victim;
        end
    end

    // ========================================================================
    // Write port with invalidation ahead of insertion
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ways <= '0;
        end
        else if (inval_en)
        begin
            wr_ways <= '1;
        end
        else if (fill_state == fill_insert)
        begin
            wr_ways <= t_way_vec'(1) << victim_way;
        end
        else
        begin
            wr_ways <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inval_en)
        begin
            // The whole set goes invalid and the tag of the page is not checked
            wr_idx <= t_tlb_idx'(inval_va);
            wr_valid <= 1'b0;
        end
        else
        begin
            wr_idx <= req_idx;
            wr_valid <= 1'b1;
        end
        wr_tag <= req_tag;
        wr_pa <= req_pa;
    end

    // An insert into a set with room writes exactly one way, and that way is still free
    a_insert_onehot: assert property (
        @(posedge clk) disable iff (reset)
        (fill_state == fill_insert && !inval_en && !set_full)
            |=> $onehot(wr_ways & ~peek_valid)
    );

    a_fill_when_rdy: assert property (
        @(posedge clk) disable iff (reset) fill_en |-> fill_rdy
    );

endmodule

`default_nettype wire

//--- hdl/tlb_top.sv
// TLB top level joining the entry store, the lookup pipeline and the fill controller
`default_nettype none

`include "tlb_defs.svh"

module tlb_top
    import tlb_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     lookup_en,
    input  t_va_page lookup_va,
    output logic     lookup_rdy,
    output logic     lookup_rsp_valid,
    output t_pa_page lookup_rsp_pa,
    output logic     lookup_miss,
    output t_va_page lookup_miss_va,
    input  logic     fill_en,
    input  t_va_page fill_va,
    input  t_pa_page fill_pa,
    output logic     fill_rdy,
    input  logic     inval_en,
    input  t_va_page inval_va,
    input  logic     flush
);

    // Read path between the lookup pipe and the store
    t_tlb_idx rd_idx;
    t_tlb_tag rd_tags [`TLB_NUM_WAYS];
    t_pa_page rd_pas [`TLB_NUM_WAYS];
    t_way_vec rd_valid;

    // Write and peek path between the fill controller and the store
    t_way_vec wr_ways;
    t_tlb_idx wr_idx;
    t_tlb_tag wr_tag;
    t_pa_page wr_pa;
    logic     wr_valid;
    t_tlb_idx peek_idx;
    t_way_vec peek_valid;

    tlb_way_store tlb_way_store_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .rd_idx     (rd_idx),
        .rd_tags    (rd_tags),
        .rd_pas     (rd_pas),
        .rd_valid   (rd_valid),
        .wr_ways    (wr_ways),
        .wr_idx     (wr_idx),
        .wr_tag     (wr_tag),
        .wr_pa      (wr_pa),
        .wr_valid   (wr_valid),
        .peek_idx   (peek_idx),
        .peek_valid (peek_valid),
        .lookup_rdy (lookup_rdy)
    );

    tlb_lookup_pipe tlb_lookup_pipe_i (
        .clk              (clk),
        .reset            (reset),
        .lookup_en        (lookup_en),
        .lookup_va        (lookup_va),
        .lookup_rdy       (lookup_rdy),
        .rd_idx           (rd_idx),
        .rd_tags          (rd_tags),
        .rd_pas           (rd_pas),
        .rd_valid         (rd_valid),
        .lookup_rsp_valid (lookup_rsp_valid),
        .lookup_rsp_pa    (lookup_rsp_pa),
        .lookup_miss      (lookup_miss),
        .lookup_miss_va   (lookup_miss_va)
    );

    tlb_fill_ctrl tlb_fill_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .fill_en    (fill_en),
        .fill_va    (fill_va),
        .fill_pa    (fill_pa),
        .fill_rdy   (fill_rdy),
        .inval_en   (inval_en),
        .inval_va   (inval_va),
        .peek_idx   (peek_idx),
        .peek_valid (peek_valid),
        .wr_ways    (wr_ways),
        .wr_idx     (wr_idx),
        .wr_tag     (wr_tag),
        .wr_pa      (wr_pa),
        .wr_valid   (wr_valid)
    );

endmodule

`default_nettype wire

//--- tests/tlb_tests.svh
// TLB directed tests: misses after reset, fills, eviction, invalidation, flush, random
// All tasks start and end just after a falling clock edge

// ============================================================================
// Driver helpers
// ============================================================================

function automatic void begin_test(string name);
    test_name = name;
    err_start = errors;
endfunction

task automatic end_test();
    $display("test %s done, %0d errors", test_name, errors - err_start);
endtask

task automatic wait_lookup_rdy();
    int n;
    n = 0;
    while (lookup_rdy !== 1'b1 && n < 100)
    begin
        @(negedge clk);
        n++;
    end
    if (lookup_rdy !== 1'b1)
    begin
        report_error($sformatf("%s: lookup_rdy stayed low after the sweep", test_name));
    end
endtask

task automatic wait_fill_rdy();
    int n;
    n = 0;
    while (fill_rdy !== 1'b1 && n < 50)
    begin
        @(negedge clk);
        n++;
    end
    if (fill_rdy !== 1'b1)
    begin
        report_error($sformatf("%s: fill_rdy did not return", test_name));
    end
endtask

task automatic wait_responses();
    int n;
    n = 0;
    while (exp_va.size() != 0 && n < 20)
    begin
        @(negedge clk);
        n++;
    end
    if (exp_va.size() != 0)
    begin
        report_error($sformatf("%s: lookups still outstanding", test_name));
    end
endtask

// Expected result comes from the model as it stands when the lookup is sampled
task automatic issue_lookup(t_va_page va);
    logic     hit;
    t_pa_page pa;
    model_lookup(va, hit, pa);
    lookup_en = 1'b1;
    lookup_va = va;
    exp_va.push_back(va);
    exp_hit.push_back(hit);
    exp_pa.push_back(pa);
    exp_due.push_back(cyc + 1 + `TLB_LOOKUP_LATENCY);
    @(negedge clk);
    lookup_en = 1'b0;
endtask

// Returns once fill_rdy is back, by which time the insert has landed
task automatic do_fill(t_va_page va, t_pa_page pa);
    wait_fill_rdy();
    fill_en = 1'b1;
    fill_va = va;
    fill_pa = pa;
    @(negedge clk);
    fill_en = 1'b0;
    model_insert(va, pa);
    filled_pages.push_back(va);
    wait_fill_rdy();
endtask

// The invalidating write lands two edges after the strobe
task automatic do_inval(t_va_page va);
    inval_en = 1'b1;
    inval_va = va;
    @(negedge clk);
    inval_en = 1'b0;
    model_clear_set(va % SETS);
    repeat (3) @(negedge clk);
endtask

task automatic lookup_filled();
    foreach (filled_pages[i])
    begin
        issue_lookup(filled_pages[i]);
    end
    wait_responses();
endtask

// ============================================================================
// Directed tests
// ============================================================================

task automatic test_reset_misses();
    begin_test("reset_misses");
    if (fill_rdy !== 1'b0 || lookup_rdy !== 1'b0)
    begin
        report_error("reset_misses: fill_rdy or lookup_rdy high while in reset");
    end
    @(negedge clk);
    if (fill_rdy !== 1'b1)
    begin
        report_error("reset_misses: fill_rdy did not rise the cycle after reset");
    end
    wait_lookup_rdy();
    issue_lookup(20'h00000);
    issue_lookup(20'hfffff);
    issue_lookup(20'h12345);
    issue_lookup(20'h8000a);
    issue_lookup(20'h0abc7);
    issue_lookup(20'h5a5a5);
    wait_responses();
    end_test();
endtask

// Set 7 stays empty here for the eviction test
task automatic test_fill_lookup();
    begin_test("fill_lookup");
    do_fill(20'h12341, 20'habc01);
    do_fill(20'h00a52, 20'h11112);
    do_fill(20'hfff0c, 20'h2345c);
    do_fill(20'h4567e, 20'h7777e);
    do_fill(20'h9999f, 20'hfedcf);
    issue_lookup(20'h12341);
    issue_lookup(20'h12342);
    issue_lookup(20'h00a52);
    issue_lookup(20'h22341);
    issue_lookup(20'hfff0c);
    issue_lookup(20'h4567e);
    issue_lookup(20'h00000);
    issue_lookup(20'h9999f);
    wait_responses();
    end_test();
endtask

// The fifth tag replaces the way the pointer names, so one page now misses
task automatic test_set_eviction();
    begin_test("set_eviction");
    for (int i = 0; i < 5; i++)
    begin
        do_fill({16'h1000 + 16'(i), 4'h7}, 20'h70000 + 20'(i));
    end
    for (int i = 0; i < 5; i++)
    begin
        issue_lookup({16'h1000 + 16'(i), 4'h7});
    end
    wait_responses();
    end_test();
endtask

task automatic test_invalidate();
    begin_test("invalidate");
    do_inval({16'h1002, 4'h7});
    lookup_filled();
    end_test();
endtask

// The model drops every valid bit but keeps its pointer
task automatic test_flush();
    begin_test("flush");
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    if (lookup_rdy !== 1'b0)
    begin
        report_error("flush: lookup_rdy stayed high after the flush strobe");
    end
    for (int s = 0; s < SETS; s++)
    begin
        model_clear_set(s);
    end
    wait_lookup_rdy();
    lookup_filled();
    end_test();
endtask

// Eight tags over four sets, so sets fill up and the pointer gets exercised
task automatic test_random();
    t_va_page   va;
    logic [3:0] op;
    int         burst;
    begin_test("random");
    for (int i = 0; i < 300; i++)
    begin
        op = 4'(rand_bits(4));
        va = {13'h0, 3'(rand_bits(3)), 2'b0, 2'(rand_bits(2))};
        if (op < 4'd5)
        begin
            do_fill(va, t_pa_page'(rand_bits(20)));
        end
        else if (op == 4'd15)
        begin
            do_inval(va);
        end
        else
        begin
            burst = 1 + int'(rand_bits(2));
            for (int b = 0; b < burst; b++)
            begin
                issue_lookup({13'h0, 3'(rand_bits(3)), 2'b0, 2'(rand_bits(2))});
            end
        end
    end
    wait_responses();
    end_test();
endtask

//--- tests/tlb_tb.sv
// TLB testbench: clock, reset, response checker, reference model and run summary
`default_nettype none

`include "tlb_defs.svh"

module tlb_tb
    import tlb_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS = 6;
    localparam int SETS = `TLB_NUM_SETS;
    localparam int WAYS = `TLB_NUM_WAYS;

    logic     clk;
    logic     reset;
    logic     lookup_en;
    t_va_page lookup_va;
    logic     lookup_rdy;
    logic     lookup_rsp_valid;
    t_pa_page lookup_rsp_pa;
    logic     lookup_miss;
    t_va_page lookup_miss_va;
    logic     fill_en;
    t_va_page fill_va;
    t_pa_page fill_pa;
    logic     fill_rdy;
    logic     inval_en;
    t_va_page inval_va;
    logic     flush;

    tlb_top tlb_top_i (
        .clk              (clk),
        .reset            (reset),
        .lookup_en        (lookup_en),
        .lookup_va        (lookup_va),
        .lookup_rdy       (lookup_rdy),
        .lookup_rsp_valid (lookup_rsp_valid),
        .lookup_rsp_pa    (lookup_rsp_pa),
        .lookup_miss      (lookup_miss),
        .lookup_miss_va   (lookup_miss_va),
        .fill_en          (fill_en),
        .fill_va          (fill_va),
        .fill_pa          (fill_pa),
        .fill_rdy         (fill_rdy),
        .inval_en         (inval_en),
        .inval_va         (inval_va),
        .flush            (flush)
    );

    // ========================================================================
    // Bookkeeping shared by the checker and the tests
    // ========================================================================

    int          cyc;
    int          errors;
    int          checks;
    int          err_start;
    string       test_name;
    logic [31:0] lfsr;

    // Outstanding lookups in issue order, with the cycle each one is due
    t_va_page exp_va [$];
    logic     exp_hit [$];
    t_pa_page exp_pa [$];
    int       exp_due [$];

    // Pages filled so far, reused later to probe invalidation and flush
    t_va_page filled_pages [$];

    // Reference model of the entry arrays and the global rotating pointer
    t_tlb_tag m_tag [SETS][WAYS];
    t_pa_page m_pa [SETS][WAYS];
    logic     m_valid [SETS][WAYS];
    t_way_idx m_ptr;

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    function automatic void report_error(string msg);
        $display("%s", msg);
        errors++;
    endfunction

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // ========================================================================
    // Reference model
    // ========================================================================

    // Victim is the lowest invalid way, else the pointer, which then advances
    function automatic void model_insert(t_va_page va, t_pa_page pa);
        int set;
        int way;
        set = va % SETS;
        way = -1;
        for (int w = WAYS - 1; w >= 0; w--)
        begin
            if (!m_valid[set][w])
            begin
                way = w;
            end
        end
        if (way < 0)
        begin
            way = m_ptr;
            m_ptr = m_ptr + 1'b1;
        end
        m_tag[set][way] = t_tlb_tag'(va / SETS);
        m_pa[set][way] = pa;
        m_valid[set][way] = 1'b1;
    endfunction

    // The lowest valid way with a matching tag supplies the physical page
    function automatic void model_lookup(input t_va_page va, output logic hit,
                                         output t_pa_page pa);
        int set;
        set = va % SETS;
        hit = 1'b0;
        pa = '0;
        for (int w = WAYS - 1; w >= 0; w--)
        begin
            if (m_valid[set][w] && m_tag[set][w] == t_tlb_tag'(va / SETS))
            begin
                hit = 1'b1;
                pa = m_pa[set][w];
            end
        end
    endfunction

    function automatic void model_clear_set(int set);
        for (int w = 0; w < WAYS; w++)
        begin
            m_valid[set][w] = 1'b0;
        end
    endfunction

    // ========================================================================
    // Response checker, sampling on the falling edge
    // ========================================================================

    task automatic check_response();
        if (lookup_rsp_valid === 1'b1 && lookup_miss === 1'b1)
        begin
            report_error($sformatf("%s: hit and miss pulsed in the same cycle", test_name));
        end
        else if (lookup_rsp_valid === 1'b1 || lookup_miss === 1'b1)
        begin
            if (exp_va.size() == 0)
            begin
                report_error($sformatf("%s: response with no lookup outstanding", test_name));
            end
            else
            begin
                checks++;
                if (cyc != exp_due[0])
                begin
                    report_error($sformatf("%s: response for va %h at cycle %0d, due at %0d",
                                           test_name, exp_va[0], cyc, exp_due[0]));
                end
                if (lookup_rsp_valid !== exp_hit[0])
                begin
                    report_error($sformatf("mismatch %s va %h: expected hit %0b actual %0b",
                                           test_name, exp_va[0], exp_hit[0],
                                           lookup_rsp_valid));
                end
                else if (exp_hit[0] && lookup_rsp_pa !== exp_pa[0])
                begin
                    report_error($sformatf("mismatch %s va %h: expected pa %h actual %h",
                                           test_name, exp_va[0], exp_pa[0], lookup_rsp_pa));
                end
                else if (!exp_hit[0] && lookup_miss_va !== exp_va[0])
                begin
                    report_error($sformatf("mismatch %s miss va: expected %h actual %h",
                                           test_name, exp_va[0], lookup_miss_va));
                end
                void'(exp_va.pop_front());
                void'(exp_hit.pop_front());
                void'(exp_pa.pop_front());
                void'(exp_due.pop_front());
            end
        end
        else if (exp_va.size() != 0 && exp_due[0] < cyc)
        begin
            report_error($sformatf("%s: lookup of va %h never got a response",
                                   test_name, exp_va[0]));
            void'(exp_va.pop_front());
            void'(exp_hit.pop_front());
            void'(exp_pa.pop_front());
            void'(exp_due.pop_front());
        end
    endtask

    initial
    begin
        forever
        begin
            @(negedge clk);
            check_response();
        end
    end

    `include "tlb_tests.svh"

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================

    initial
    begin
        reset = 1'b1;
        lookup_en = 1'b0;
        lookup_va = '0;
        fill_en = 1'b0;
        fill_va = '0;
        fill_pa = '0;
        inval_en = 1'b0;
        inval_va = '0;
        flush = 1'b0;
        cyc = 0;
        errors = 0;
        checks = 0;
        lfsr = 32'hc999_0677;
        m_ptr = '0;
        for (int s = 0; s < SETS; s++)
        begin
            model_clear_set(s);
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_misses();
        test_fill_lookup();
        test_set_eviction();
        test_invalidate();
        test_flush();
        test_random();

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

    // Generous budget per test, far beyond the longest fill-heavy test
    initial
    begin
        #(NUM_TESTS * 4000 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb.f
+incdir+.
+incdir+tests
hdl/tlb_pkg.sv
hdl/tlb_way_store.sv
hdl/tlb_lookup_pipe.sv
hdl/tlb_fill_ctrl.sv
hdl/tlb_top.sv
tests/tlb_tb.sv

//--- Bender.yml
package:
  name: tlb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hdl/tlb_pkg.sv
      - hdl/tlb_way_store.sv
      - hdl/tlb_lookup_pipe.sv
      - hdl/tlb_fill_ctrl.sv
      - hdl/tlb_top.sv

  - target: test
    include_dirs:
      - .
      - tests
    files:
      - tests/tlb_tb.sv
